/* rtl/cpu_pkg.sv */
package cpu_pkg;

    // datapath words, also used for instructions and byte addresses
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // operand source for the execute stage
    typedef logic [1:0]  fwd_sel_t;

    localparam fwd_sel_t FWD_REG = 2'd0;
    localparam fwd_sel_t FWD_MEM = 2'd1;
    localparam fwd_sel_t FWD_WB  = 2'd2;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    // opcodes, instruction bits 31:26
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type funct field, bits 5:0
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    localparam int NUM_REGS = 32;

endpackage

/* rtl/pipe_ifs.sv */
`timescale 1ns/1ns

// decode to execute boundary
interface id_ex_if;
    import cpu_pkg::*;

    word_t      pc, pc4;
    word_t      data1, data2;
    word_t      seimm;
    reg_addr_t  rs, rt, rd;
    logic       regdst, alusrc, memread, memwrite, memtoreg, regwrite;
    logic       branch_eq, branch_ne, jump;
    logic [5:0] funct;
    logic [1:0] aluop;
    word_t      baddr, jaddr;

    modport src (output pc, pc4, data1, data2, seimm, rs, rt, rd, regdst, alusrc,
                 memread, memwrite, memtoreg, regwrite, branch_eq, branch_ne, jump,
                 funct, aluop, baddr, jaddr);
    modport dst (input pc, pc4, data1, data2, seimm, rs, rt, rd, regdst, alusrc,
                 memread, memwrite, memtoreg, regwrite, branch_eq, branch_ne, jump,
                 funct, aluop, baddr, jaddr);
endinterface

// execute to memory boundary
interface ex_mem_if;
    import cpu_pkg::*;

    word_t     pc, alu_result, store_data;
    reg_addr_t wrreg;
    logic      regwrite, memread, memwrite, memtoreg;
    logic      branch_eq, branch_ne, zero, jump;
    word_t     baddr, jaddr;

    modport src (output pc, alu_result, store_data, wrreg, regwrite, memread, memwrite,
                 memtoreg, branch_eq, branch_ne, zero, jump, baddr, jaddr);
    modport dst (input pc, alu_result, store_data, wrreg, regwrite, memread, memwrite,
                 memtoreg, branch_eq, branch_ne, zero, jump, baddr, jaddr);
endinterface

// memory to writeback boundary, wrdata already selected
interface mem_wb_if;
    import cpu_pkg::*;

    word_t     pc;
    reg_addr_t wrreg;
    logic      regwrite;
    word_t     wrdata;

    modport src (output pc, wrreg, regwrite, wrdata);
    modport dst (input pc, wrreg, regwrite, wrdata);
endinterface

/* rtl/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  logic           clk,
    input  logic           resetn,
    input  logic           stall,
    input  logic           flush,
    input  logic           redirect,
    input  cpu_pkg::word_t redirect_pc,
    input  cpu_pkg::word_t inst_rdata,
    output cpu_pkg::word_t inst_addr,
    output cpu_pkg::word_t pc_id,
    output cpu_pkg::word_t pc4_id,
    output cpu_pkg::word_t inst_id
);
    import cpu_pkg::*;

    word_t pc;
    word_t pc4;

    assign pc4       = pc + 32'd4;
    assign inst_addr = pc;

    // redirect wins over a held PC
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc4;
        end
    end

    // IF/ID, a flushed slot becomes a nop
    always_ff @(posedge clk) begin
        if (flush) begin
            inst_id <= '0;
        end else if (!stall) begin
            inst_id <= inst_rdata;
        end
        if (!stall) begin
            pc_id  <= pc;
            pc4_id <= pc4;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!resetn)
        pc[1:0] == 2'b00);

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic               clk,
    input  logic               resetn,
    input  logic               stall,
    input  logic               flush,
    input  cpu_pkg::word_t     pc_id,
    input  cpu_pkg::word_t     pc4_id,
    input  cpu_pkg::word_t     inst_id,
    mem_wb_if.dst              wb,
    id_ex_if.src               ex,
    output cpu_pkg::reg_addr_t rs_id,
    output cpu_pkg::reg_addr_t rt_id
);
    import cpu_pkg::*;

    logic [5:0] opcode;
    reg_addr_t  rd;
    word_t      seimm;
    word_t      baddr;
    word_t      jaddr;
    word_t      data1, data2;
    word_t      regs [NUM_REGS];

    logic       regdst, alusrc, memread, memwrite, memtoreg, regwrite;
    logic       branch_eq, branch_ne, jump;
    logic [1:0] aluop;

    assign opcode = inst_id[31:26];
    assign rs_id  = inst_id[25:21];
    assign rt_id  = inst_id[20:16];
    assign rd     = inst_id[15:11];
    assign seimm  = {{16{inst_id[15]}}, inst_id[15:0]};
    assign baddr  = pc4_id + {seimm[29:0], 2'b00};
    assign jaddr  = {pc4_id[31:28], inst_id[25:0], 2'b00};

    // main control
    // aluop class: 00 add, 01 subtract for compare, 10 from funct
    always_comb begin
        regdst    = 1'b0;
        alusrc    = 1'b0;
        memread   = 1'b0;
        memwrite  = 1'b0;
        memtoreg  = 1'b0;
        regwrite  = 1'b0;
        branch_eq = 1'b0;
        branch_ne = 1'b0;
        jump      = 1'b0;
        aluop     = 2'b00;
        case (opcode)
            OP_RTYPE: begin
                regdst   = 1'b1;
                aluop    = 2'b10;
                // rd of zero covers the all-zero nop
                regwrite = (rd != '0);
            end
            OP_ADDI: begin
                alusrc   = 1'b1;
                regwrite = 1'b1;
            end
            OP_LW: begin
                alusrc   = 1'b1;
                memread  = 1'b1;
                memtoreg = 1'b1;
                regwrite = 1'b1;
            end
            OP_SW: begin
                alusrc   = 1'b1;
                memwrite = 1'b1;
            end
            OP_BEQ: begin
                branch_eq = 1'b1;
                aluop     = 2'b01;
            end
            OP_BNE: begin
                branch_ne = 1'b1;
                aluop     = 2'b01;
            end
            OP_J:    jump = 1'b1;
            default: ;
        endcase
    end

    // register file, $0 ignores writes
    always_ff @(posedge clk) begin
        if (wb.regwrite && wb.wrreg != '0) begin
            regs[wb.wrreg] <= wb.wrdata;
        end
    end

    // same-cycle writeback bypass
    always_comb begin
        if (rs_id == '0) begin
            data1 = '0;
        end else if (wb.regwrite && wb.wrreg == rs_id) begin
            data1 = wb.wrdata;
        end else begin
            data1 = regs[rs_id];
        end
        if (rt_id == '0) begin
            data2 = '0;
        end else if (wb.regwrite && wb.wrreg == rt_id) begin
            data2 = wb.wrdata;
        end else begin
            data2 = regs[rt_id];
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        ex.pc    <= pc_id;
        ex.pc4   <= pc4_id;
        ex.data1 <= data1;
        ex.data2 <= data2;
        ex.seimm <= seimm;
        ex.rs    <= rs_id;
        ex.rt    <= rt_id;
        ex.rd    <= rd;
        ex.funct <= inst_id[5:0];
        ex.baddr <= baddr;
        ex.jaddr <= jaddr;
    end

    // ID/EX controls, a stall leaves a bubble behind
    always_ff @(posedge clk) begin
        if (!resetn || flush || stall) begin
            ex.regdst    <= 1'b0;
            ex.alusrc    <= 1'b0;
            ex.memread   <= 1'b0;
            ex.memwrite  <= 1'b0;
            ex.memtoreg  <= 1'b0;
            ex.regwrite  <= 1'b0;
            ex.branch_eq <= 1'b0;
            ex.branch_ne <= 1'b0;
            ex.jump      <= 1'b0;
            ex.aluop     <= 2'b00;
        end else begin
            ex.regdst    <= regdst;
            ex.alusrc    <= alusrc;
            ex.memread   <= memread;
            ex.memwrite  <= memwrite;
            ex.memtoreg  <= memtoreg;
            ex.regwrite  <= regwrite;
            ex.branch_eq <= branch_eq;
            ex.branch_ne <= branch_ne;
            ex.jump      <= jump;
            ex.aluop     <= aluop;
        end
    end

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  logic              clk,
    input  logic              resetn,
    input  logic              flush,
    input  cpu_pkg::fwd_sel_t fwd_a,
    input  cpu_pkg::fwd_sel_t fwd_b,
    id_ex_if.dst              id,
    mem_wb_if.dst             wb,
    ex_mem_if.src             mem
);
    import cpu_pkg::*;

    word_t     op_a, op_b, alu_b;
    word_t     result;
    alu_op_t   alu_op;
    logic      funct_ok;
    reg_addr_t wrreg;

    // forwarding muxes
    always_comb begin
        case (fwd_a)
            FWD_MEM: op_a = mem.alu_result;
            FWD_WB:  op_a = wb.wrdata;
            default: op_a = id.data1;
        endcase
        case (fwd_b)
            FWD_MEM: op_b = mem.alu_result;
            FWD_WB:  op_b = wb.wrdata;
            default: op_b = id.data2;
        endcase
    end

    assign alu_b = id.alusrc ? id.seimm : op_b;
    assign wrreg = id.regdst ? id.rd : id.rt;

    // ALU control
    always_comb begin
        funct_ok = 1'b1;
        case (id.aluop)
            2'b01: alu_op = ALU_SUB;
            2'b10: begin
                case (id.funct)
                    FN_ADD: alu_op = ALU_ADD;
                    FN_SUB: alu_op = ALU_SUB;
                    FN_AND: alu_op = ALU_AND;
                    FN_OR:  alu_op = ALU_OR;
                    FN_SLT: alu_op = ALU_SLT;
                    default: begin
                        alu_op   = ALU_ADD;
                        funct_ok = 1'b0;
                    end
                endcase
            end
            default: alu_op = ALU_ADD;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_SUB: result = op_a - alu_b;
            ALU_AND: result = op_a & alu_b;
            ALU_OR:  result = op_a | alu_b;
            ALU_SLT: result = ($signed(op_a) < $signed(alu_b)) ? 32'd1 : 32'd0;
            default: result = op_a + alu_b;
        endcase
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        mem.pc         <= id.pc;
        mem.alu_result <= result;
        mem.store_data <= op_b;
        mem.wrreg      <= wrreg;
        mem.zero       <= (result == '0);
        mem.baddr      <= id.baddr;
        mem.jaddr      <= id.jaddr;
    end

    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            mem.regwrite  <= 1'b0;
            mem.memread   <= 1'b0;
            mem.memwrite  <= 1'b0;
            mem.memtoreg  <= 1'b0;
            mem.branch_eq <= 1'b0;
            mem.branch_ne <= 1'b0;
            mem.jump      <= 1'b0;
        end else begin
            mem.regwrite  <= id.regwrite;
            mem.memread   <= id.memread;
            mem.memwrite  <= id.memwrite;
            mem.memtoreg  <= id.memtoreg;
            mem.branch_eq <= id.branch_eq;
            mem.branch_ne <= id.branch_ne;
            mem.jump      <= id.jump;
        end
    end

    a_known_funct: assert property (@(posedge clk) disable iff (!resetn)
        (id.regwrite && id.aluop == 2'b10) |-> funct_ok);

endmodule

/* rtl/memory_stage.sv */
`timescale 1ns/1ns

module memory_stage (
    input  logic           clk,
    input  logic           resetn,
    ex_mem_if.dst          ex,
    output logic           data_en,
    output logic [3:0]     data_wen,
    output cpu_pkg::word_t data_addr,
    output cpu_pkg::word_t data_wdata,
    input  cpu_pkg::word_t data_rdata,
    output logic           redirect,
    output cpu_pkg::word_t redirect_pc,
    mem_wb_if.src          wb
);
    import cpu_pkg::*;

    logic taken;

    // word stores only
    assign data_en    = ex.memread | ex.memwrite;
    assign data_wen   = {4{ex.memwrite}};
    assign data_addr  = ex.alu_result;
    assign data_wdata = ex.store_data;

    // zero came from rs - rt
    assign taken       = (ex.branch_eq & ex.zero) | (ex.branch_ne & ~ex.zero);
    assign redirect    = taken | ex.jump;
    assign redirect_pc = ex.jump ? ex.jaddr : ex.baddr;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb.regwrite <= 1'b0;
        end else begin
            wb.regwrite <= ex.regwrite;
        end
        wb.pc     <= ex.pc;
        wb.wrreg  <= ex.wrreg;
        wb.wrdata <= ex.memtoreg ? data_rdata : ex.alu_result;
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(ex.memread && ex.memwrite));

endmodule

/* rtl/hazard_unit.sv */
`timescale 1ns/1ns

module hazard_unit (
    input  logic               resetn,
    input  logic               redirect,
    input  cpu_pkg::reg_addr_t rs_id,
    input  cpu_pkg::reg_addr_t rt_id,
    id_ex_if.dst               id,
    ex_mem_if.dst              mem,
    mem_wb_if.dst              wb,
    output logic               stall,
    output logic               flush,
    output cpu_pkg::fwd_sel_t  fwd_a,
    output cpu_pkg::fwd_sel_t  fwd_b
);
    import cpu_pkg::*;

    // newest producer first, $0 never forwards
    function automatic fwd_sel_t pick(input reg_addr_t src);
        if (src != '0 && mem.regwrite && mem.wrreg == src) begin
            return FWD_MEM;
        end else if (src != '0 && wb.regwrite && wb.wrreg == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign fwd_a = pick(id.rs);
    assign fwd_b = pick(id.rt);

    // a squashed load needs no bubble
    always_comb begin
        flush = redirect | ~resetn;
        stall = id.memread && (id.rt == rs_id || id.rt == rt_id) && !flush;
    end

    always_comb begin
        if (resetn) begin
            a_stall_flush: assert (!(stall && flush));
        end
    end

endmodule

/* rtl/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  logic               clk,
    input  logic               resetn,
    output logic               inst_sram_en,
    output cpu_pkg::word_t     inst_sram_addr,
    input  cpu_pkg::word_t     inst_sram_rdata,
    output logic               data_sram_en,
    output logic [3:0]         data_sram_wen,
    output cpu_pkg::word_t     data_sram_addr,
    output cpu_pkg::word_t     data_sram_wdata,
    input  cpu_pkg::word_t     data_sram_rdata,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic               debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic      stall, flush, redirect;
    word_t     redirect_pc;
    word_t     pc_id, pc4_id, inst_id;
    reg_addr_t rs_id, rt_id;
    fwd_sel_t  fwd_a, fwd_b;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();
    mem_wb_if mem_wb ();

    // fetch every cycle
    assign inst_sram_en = 1'b1;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .resetn(resetn), .stall(stall), .flush(flush),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .inst_rdata(inst_sram_rdata), .inst_addr(inst_sram_addr),
        .pc_id(pc_id), .pc4_id(pc4_id), .inst_id(inst_id)
    );

    decode_stage u_decode (
        .clk(clk), .resetn(resetn), .stall(stall), .flush(flush),
        .pc_id(pc_id), .pc4_id(pc4_id), .inst_id(inst_id),
        .wb(mem_wb.dst), .ex(id_ex.src), .rs_id(rs_id), .rt_id(rt_id)
    );

    execute_stage u_execute (
        .clk(clk), .resetn(resetn), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .id(id_ex.dst), .wb(mem_wb.dst), .mem(ex_mem.src)
    );

    memory_stage u_memory (
        .clk(clk), .resetn(resetn), .ex(ex_mem.dst),
        .data_en(data_sram_en), .data_wen(data_sram_wen),
        .data_addr(data_sram_addr), .data_wdata(data_sram_wdata),
        .data_rdata(data_sram_rdata),
        .redirect(redirect), .redirect_pc(redirect_pc), .wb(mem_wb.src)
    );

    hazard_unit u_hazard (
        .resetn(resetn), .redirect(redirect), .rs_id(rs_id), .rt_id(rt_id),
        .id(id_ex.dst), .mem(ex_mem.dst), .wb(mem_wb.dst),
        .stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    // writes to $0 stay invisible
    assign debug_wb_pc       = mem_wb.pc;
    assign debug_wb_rf_wen   = mem_wb.regwrite && (mem_wb.wrreg != '0);
    assign debug_wb_rf_wnum  = mem_wb.wrreg;
    assign debug_wb_rf_wdata = mem_wb.wrdata;

endmodule

/* dv/tb_cpu.sv */
`timescale 1ns/1ns

module tb_cpu;
    import cpu_pkg::*;

    localparam word_t RESET_PC     = 32'h0000_0100;
    localparam int    PERIOD       = 40;
    localparam int    RESET_CYCLES = 8;
    localparam int    PROG_LEN     = 36;
    // four cycles per instruction at worst, plus drain time
    localparam int    WATCHDOG_NS  = PERIOD * (RESET_CYCLES + PROG_LEN * 4 + 40);

    logic       clk;
    logic       resetn;
    logic       inst_sram_en;
    word_t      inst_sram_addr, inst_sram_rdata;
    logic       data_sram_en;
    logic [3:0] data_sram_wen;
    word_t      data_sram_addr, data_sram_wdata, data_sram_rdata;
    word_t      debug_wb_pc;
    logic       debug_wb_rf_wen;
    reg_addr_t  debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t  imem [64];
    word_t  dmem [64];
    word_t  imem_off;
    integer seed = 48898;

    // retirement and store trace of the reference model
    word_t     wb_pc_q [$];
    reg_addr_t wb_num_q [$];
    word_t     wb_data_q [$];
    word_t     st_pc_q [$];
    word_t     st_addr_q [$];
    word_t     st_data_q [$];
    int        wb_idx = 0;
    int        st_idx = 0;

    logic      exp_wb_valid, exp_st_valid;
    word_t     exp_wb_pc, exp_wb_data, exp_st_addr, exp_st_data;
    reg_addr_t exp_wb_num;
    int        exp_wb_seg, exp_st_seg;

    int   seg_total [5];
    int   seg_seen [5];
    int   seg_errs [5];
    int   pass_cnt, fail_cnt, total_errs;
    logic quiet_window;

    cpu_top #(.RESET_PC(RESET_PC)) uut (
        .clk(clk), .resetn(resetn),
        .inst_sram_en(inst_sram_en), .inst_sram_addr(inst_sram_addr),
        .inst_sram_rdata(inst_sram_rdata),
        .data_sram_en(data_sram_en), .data_sram_wen(data_sram_wen),
        .data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata),
        .data_sram_rdata(data_sram_rdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    // both SRAMs answer in the same cycle
    assign imem_off        = inst_sram_addr - RESET_PC;
    assign inst_sram_rdata = inst_sram_en ? imem[imem_off[7:2]] : '0;
    assign data_sram_rdata = data_sram_en ? dmem[data_sram_addr[7:2]] : '0;

    always @(posedge clk) begin
        if (data_sram_en && data_sram_wen != 4'h0) begin
            dmem[data_sram_addr[7:2]] <= data_sram_wdata;
        end
    end

    function automatic word_t addr_of(input int idx);
        return RESET_PC + 32'(idx * 4);
    endfunction

    function automatic word_t enc_r(input logic [5:0] fn, input int rd, input int rs,
                                    input int rt);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input int rt, input int rs,
                                    input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic word_t enc_j(input int idx);
        word_t target;
        target = addr_of(idx);
        return {OP_J, target[27:2]};
    endfunction

    // program segments by instruction index
    function automatic int seg_of(input word_t pc);
        word_t off;
        off = (pc - RESET_PC) >> 2;
        if (off < 9) return 1;
        if (off < 14) return 2;
        if (off < 19) return 3;
        return 4;
    endfunction

    function automatic string test_name(input int s);
        case (s)
            0:       return "reset";
            1:       return "alu forwarding";
            2:       return "load use";
            3:       return "store and load";
            default: return "control flow";
        endcase
    endfunction

    task automatic load_program();
        foreach (imem[i]) imem[i] = '0;
        imem[0]  = enc_i(OP_ADDI, 1, 0, 5);
        imem[1]  = enc_i(OP_ADDI, 2, 0, -3);
        imem[2]  = enc_r(FN_ADD, 3, 1, 2);
        imem[3]  = enc_r(FN_SUB, 4, 3, 1);
        imem[4]  = enc_r(FN_AND, 5, 4, 3);
        imem[5]  = enc_r(FN_OR, 6, 5, 2);
        imem[6]  = enc_r(FN_SLT, 7, 2, 1);
        imem[7]  = enc_r(FN_SLT, 8, 1, 6);
        imem[8]  = enc_i(OP_ADDI, 9, 7, 100);
        imem[9]  = enc_i(OP_ADDI, 10, 0, 16);
        imem[10] = enc_i(OP_LW, 11, 10, 0);
        imem[11] = enc_r(FN_ADD, 12, 11, 1);
        imem[12] = enc_i(OP_LW, 13, 10, 4);
        imem[13] = enc_r(FN_OR, 14, 13, 12);
        imem[14] = enc_i(OP_SW, 12, 10, 8);
        imem[15] = enc_i(OP_SW, 9, 10, 12);
        imem[16] = enc_i(OP_LW, 15, 10, 8);
        imem[17] = enc_i(OP_LW, 16, 10, 12);
        imem[18] = enc_r(FN_ADD, 17, 15, 16);
        // not taken, then taken bne over three slots
        imem[19] = enc_i(OP_BEQ, 2, 1, 4);
        imem[20] = enc_i(OP_ADDI, 18, 0, 7);
        imem[21] = enc_i(OP_BNE, 2, 1, 3);
        imem[22] = enc_i(OP_ADDI, 19, 0, 1);
        imem[23] = enc_i(OP_ADDI, 20, 0, 2);
        imem[24] = enc_i(OP_ADDI, 21, 0, 3);
        imem[25] = enc_i(OP_BEQ, 18, 18, 2);
        imem[26] = enc_i(OP_ADDI, 22, 0, 4);
        imem[27] = enc_i(OP_ADDI, 23, 0, 5);
        imem[28] = enc_i(OP_ADDI, 0, 0, 9);
        imem[29] = enc_j(32);
        imem[30] = enc_i(OP_ADDI, 24, 0, 6);
        imem[31] = enc_i(OP_ADDI, 25, 0, 7);
        imem[32] = enc_r(FN_ADD, 26, 18, 1);
        imem[33] = enc_i(OP_BNE, 26, 26, 5);
        imem[34] = enc_i(OP_ADDI, 27, 26, -1);
        imem[35] = enc_j(35);
    endtask

    // architectural model, one instruction per step
    task automatic run_model();
        word_t     regs [32];
        word_t     mmem [64];
        word_t     pc, pc4, next, off, ins, a, b, seimm, res, addr;
        reg_addr_t rs, rt, rd;
        logic      done;
        int        steps;
        foreach (regs[i]) regs[i] = '0;
        foreach (dmem[i]) mmem[i] = dmem[i];
        pc    = RESET_PC;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 4 * PROG_LEN) begin
            off   = pc - RESET_PC;
            ins   = imem[off[7:2]];
            rs    = ins[25:21];
            rt    = ins[20:16];
            rd    = ins[15:11];
            a     = regs[rs];
            b     = regs[rt];
            seimm = {{16{ins[15]}}, ins[15:0]};
            addr  = a + seimm;
            pc4   = pc + 32'd4;
            next  = pc4;
            steps = steps + 1;
            case (ins[31:26])
                OP_RTYPE: begin
                    case (ins[5:0])
                        FN_SUB:  res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: res = a + b;
                    endcase
                    if (rd != '0) begin
                        regs[rd] = res;
                        wb_pc_q.push_back(pc);
                        wb_num_q.push_back(rd);
                        wb_data_q.push_back(res);
                        seg_total[seg_of(pc)] += 1;
                    end
                end
                OP_ADDI, OP_LW: begin
                    res = (ins[31:26] == OP_LW) ? mmem[addr[7:2]] : addr;
                    if (rt != '0) begin
                        regs[rt] = res;
                        wb_pc_q.push_back(pc);
                        wb_num_q.push_back(rt);
                        wb_data_q.push_back(res);
                        seg_total[seg_of(pc)] += 1;
                    end
                end
                OP_SW: begin
                    mmem[addr[7:2]] = b;
                    st_pc_q.push_back(pc);
                    st_addr_q.push_back(addr);
                    st_data_q.push_back(b);
                    seg_total[seg_of(pc)] += 1;
                end
                OP_BEQ: if (a == b) next = pc4 + {seimm[29:0], 2'b00};
                OP_BNE: if (a != b) next = pc4 + {seimm[29:0], 2'b00};
                OP_J: begin
                    next = {pc4[31:28], ins[25:0], 2'b00};
                    // a jump to itself ends the program
                    done = (next == pc);
                end
                default: ;
            endcase
            pc = next;
        end
    endtask

    task automatic load_expected();
        exp_wb_valid = (wb_idx < wb_pc_q.size());
        exp_st_valid = (st_idx < st_addr_q.size());
        if (exp_wb_valid) begin
            exp_wb_pc   = wb_pc_q[wb_idx];
            exp_wb_num  = wb_num_q[wb_idx];
            exp_wb_data = wb_data_q[wb_idx];
            exp_wb_seg  = seg_of(exp_wb_pc);
        end
        if (exp_st_valid) begin
            exp_st_addr = st_addr_q[st_idx];
            exp_st_data = st_data_q[st_idx];
            exp_st_seg  = seg_of(st_pc_q[st_idx]);
        end
    endtask

    task automatic finish_test(input int s);
        if (seg_errs[s] == 0) begin
            pass_cnt = pass_cnt + 1;
            $display("test %0d %s: ok", s, test_name(s));
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("test %0d %s: failed with %0d errors", s, test_name(s), seg_errs[s]);
        end
    endtask

    task automatic count_event(input int s);
        seg_seen[s] = seg_seen[s] + 1;
        if (seg_seen[s] == seg_total[s]) begin
            finish_test(s);
        end
    endtask

    task automatic note_mismatch(input int s, input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        seg_errs[s] = seg_errs[s] + 1;
        total_errs  = total_errs + 1;
    endtask

    task automatic note_failure(input int s, input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        seg_errs[s] = seg_errs[s] + 1;
        total_errs  = total_errs + 1;
    endtask

    // events seen during the past cycle move the model on
    always @(posedge clk) begin
        if (resetn) begin
            if (debug_wb_rf_wen && exp_wb_valid) begin
                count_event(exp_wb_seg);
                wb_idx = wb_idx + 1;
            end
            if (data_sram_wen != 4'h0 && exp_st_valid) begin
                count_event(exp_st_seg);
                st_idx = st_idx + 1;
            end
            load_expected();
        end
    end

    // checks sample mid-cycle, away from both update points
    a_reset_quiet: assert property (@(negedge clk)
        quiet_window |-> (!debug_wb_rf_wen && data_sram_wen == 4'h0))
        else note_failure(0, "write enable raised during reset");

    a_reset_pc: assert property (@(negedge clk) !resetn |-> inst_sram_addr == RESET_PC)
        else note_mismatch(0, $sformatf("fetch address %h in reset, expected %h",
                                        inst_sram_addr, RESET_PC));

    a_wb_known: assert property (@(negedge clk) disable iff (!resetn)
        debug_wb_rf_wen |-> exp_wb_valid)
        else note_failure(4, $sformatf("register write at pc %h after the last retirement",
                                       debug_wb_pc));

    a_wb_zero: assert property (@(negedge clk) disable iff (!resetn)
        debug_wb_rf_wen |-> debug_wb_rf_wnum != '0)
        else note_failure(exp_wb_seg, "register 0 write shown on the debug port");

    a_wb_pc: assert property (@(negedge clk) disable iff (!resetn)
        (debug_wb_rf_wen && exp_wb_valid) |-> debug_wb_pc == exp_wb_pc)
        else note_mismatch(exp_wb_seg, $sformatf("retired pc %h, expected %h",
                                                 debug_wb_pc, exp_wb_pc));

    a_wb_num: assert property (@(negedge clk) disable iff (!resetn)
        (debug_wb_rf_wen && exp_wb_valid) |-> debug_wb_rf_wnum == exp_wb_num)
        else note_mismatch(exp_wb_seg, $sformatf("pc %h wrote r%0d, expected r%0d",
                                                 debug_wb_pc, debug_wb_rf_wnum, exp_wb_num));

    a_wb_data: assert property (@(negedge clk) disable iff (!resetn)
        (debug_wb_rf_wen && exp_wb_valid) |-> debug_wb_rf_wdata == exp_wb_data)
        else note_mismatch(exp_wb_seg, $sformatf("pc %h wrote %h, expected %h",
                                                 debug_wb_pc, debug_wb_rf_wdata, exp_wb_data));

    a_st_known: assert property (@(negedge clk) disable iff (!resetn)
        data_sram_wen != 4'h0 |-> exp_st_valid)
        else note_failure(4, "data write with no store left in the program");

    a_st_lanes: assert property (@(negedge clk) disable iff (!resetn)
        data_sram_wen != 4'h0 |-> data_sram_wen == 4'hf)
        else note_mismatch(exp_st_seg, $sformatf("store lanes %b, expected 1111",
                                                 data_sram_wen));

    a_st_value: assert property (@(negedge clk) disable iff (!resetn)
        (data_sram_wen != 4'h0 && exp_st_valid) |->
            (data_sram_addr == exp_st_addr && data_sram_wdata == exp_st_data))
        else note_mismatch(exp_st_seg, $sformatf("store %h to %h, expected %h to %h",
                                                 data_sram_wdata, data_sram_addr,
                                                 exp_st_data, exp_st_addr));

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: program did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        resetn       = 1'b0;
        quiet_window = 1'b1;
        pass_cnt     = 0;
        fail_cnt     = 0;
        total_errs   = 0;
        for (int s = 0; s < 5; s++) begin
            seg_total[s] = 0;
            seg_seen[s]  = 0;
            seg_errs[s]  = 0;
        end
        foreach (dmem[i]) dmem[i] = $random(seed);
        load_program();
        run_model();
        load_expected();
        repeat (RESET_CYCLES) @(posedge clk);
        #2 resetn = 1'b1;
        // one more quiet cycle after release
        @(posedge clk);
        #2 quiet_window = 1'b0;
        finish_test(0);
        while (wb_idx < wb_pc_q.size() || st_idx < st_addr_q.size()) begin
            @(posedge clk);
        end
        // room for any stray retirement
        repeat (8) @(posedge clk);
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && total_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/cpu_pkg.sv
rtl/pipe_ifs.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/hazard_unit.sv
rtl/cpu_top.sv
dv/tb_cpu.sv

/* run.sh */
#!/bin/sh
# build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_cpu -o tb_cpu

result=$(./obj_dir/tb_cpu || true)
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
